// File: source/stash_pkg.sv
package stash_pkg;

    // --------------------------------------------------------------------
    // Default geometry
    // --------------------------------------------------------------------

    // Key width in bits
    localparam int DEF_KEY_W = 8;

    // Value width in bits
    localparam int DEF_VALUE_W = 16;

    // Number of entries in the store
    localparam int DEF_SIZE = 8;

    // --------------------------------------------------------------------
    // Enumerations
    // --------------------------------------------------------------------

    // Operation issued by the controller to the store
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_CLEAR = 2'd3
    } op_e;

    // Controller FSM states
    typedef enum logic {
        ST_INIT = 1'b0,  // clear sweep in progress
        ST_IDLE = 1'b1   // normal service
    } ctrl_state_e;

endpackage

// File: source/stash_ctrl.sv
`timescale 1ns/1ps

module stash_ctrl #(
    parameter int KEY_W   = stash_pkg::DEF_KEY_W,
    parameter int VALUE_W = stash_pkg::DEF_VALUE_W,
    parameter int SIZE    = stash_pkg::DEF_SIZE
)(
    input  logic                    clk,
    input  logic                    rst,

    // Init control
    input  logic                    init,
    output logic                    init_done,

    // Write request
    input  logic                    wr_req,
    input  logic [KEY_W-1:0]        wr_key,
    input  logic [VALUE_W-1:0]      wr_value,
    output logic                    wr_rdy,

    // Read request
    input  logic                    rd_req,
    input  logic [KEY_W-1:0]        rd_key,
    output logic                    rd_rdy,

    // Store command
    output stash_pkg::op_e          op,
    output logic [KEY_W-1:0]        op_key,
    output logic [VALUE_W-1:0]      op_value,
    output logic [$clog2(SIZE)-1:0] clr_idx,

    // Store lookup result
    input  logic                    lookup_hit,
    input  logic [VALUE_W-1:0]      lookup_value,

    // Read response
    output logic                    rd_ack,
    output logic                    rd_hit,
    output logic [VALUE_W-1:0]      rd_value
);

    import stash_pkg::*;

    localparam int IDX_W = $clog2(SIZE);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SIZE - 1);

    ctrl_state_e      state;
    logic [IDX_W-1:0] clr_cnt;
    logic             wr_acc;
    logic             rd_acc;

    // --------------------------------------------------------------------
    // Handshakes
    // --------------------------------------------------------------------

    assign init_done = (state == ST_IDLE);

    // Writes win a same-cycle conflict
    assign wr_rdy = init_done;
    assign rd_rdy = init_done && !wr_req;

    assign wr_acc = wr_req && wr_rdy;
    assign rd_acc = rd_req && rd_rdy;

    // --------------------------------------------------------------------
    // Init sweep FSM
    // --------------------------------------------------------------------

    // One entry cleared per cycle, SIZE cycles in total
    always_ff @(posedge clk) begin
        if (rst || init) begin
            state   <= ST_INIT;
            clr_cnt <= '0;
        end else if (state == ST_INIT) begin
            if (clr_cnt == LAST_IDX) begin
                state   <= ST_IDLE;
                clr_cnt <= '0;
            end else begin
                clr_cnt <= clr_cnt + 1'b1;
            end
        end
    end

    assign clr_idx = clr_cnt;

    // --------------------------------------------------------------------
    // Command to the store
    // --------------------------------------------------------------------

    always_comb begin
        op = OP_NOP;
        if (state == ST_INIT) begin
            op = OP_CLEAR;
        end else if (wr_acc) begin
            op = OP_WRITE;
        end else if (rd_acc) begin
            op = OP_READ;
        end
    end

    // Key follows whichever request is being served
    assign op_key   = wr_acc ? wr_key : rd_key;
    assign op_value = wr_value;

    // --------------------------------------------------------------------
    // Registered read response
    // --------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ack <= 1'b0;
            rd_hit <= 1'b0;
        end else begin
            rd_ack <= rd_acc;
            if (rd_acc) begin
                rd_hit <= lookup_hit;
            end
        end
    end

    // Store returns zero on a miss
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_value <= lookup_value;
        end
    end

    // No response while a clear sweep is running
    a_ack_after_init: assert property (@(posedge clk) disable iff (rst)
        rd_ack |-> init_done);

endmodule

// File: source/lru_store.sv
`timescale 1ns/1ps

module lru_store #(
    parameter int KEY_W   = stash_pkg::DEF_KEY_W,
    parameter int VALUE_W = stash_pkg::DEF_VALUE_W,
    parameter int SIZE    = stash_pkg::DEF_SIZE
)(
    input  logic                    clk,
    input  logic                    rst,

    // Command from the controller
    input  stash_pkg::op_e          op,
    input  logic [KEY_W-1:0]        op_key,
    input  logic [VALUE_W-1:0]      op_value,
    input  logic [$clog2(SIZE)-1:0] clr_idx,

    // Lookup result for op_key, same cycle
    output logic                    lookup_hit,
    output logic [VALUE_W-1:0]      lookup_value,

    // Event pulses in the issue cycle
    output logic                    ins_new,
    output logic                    evict
);

    import stash_pkg::*;

    localparam int IDX_W = $clog2(SIZE);
    localparam int AGE_W = $clog2(SIZE);

    // Age of the least recently used entry in a full store
    localparam logic [AGE_W-1:0] OLDEST = AGE_W'(SIZE - 1);

    // --------------------------------------------------------------------
    // Entry storage
    // --------------------------------------------------------------------

    logic [SIZE-1:0]    valid;
    logic [KEY_W-1:0]   keys   [SIZE];
    logic [VALUE_W-1:0] values [SIZE];
    logic [AGE_W-1:0]   ages   [SIZE];

    // Lookup and replacement helpers
    logic [SIZE-1:0]    match;
    logic [IDX_W-1:0]   hit_idx;
    logic [IDX_W-1:0]   free_idx;
    logic [IDX_W-1:0]   victim_idx;
    logic [IDX_W-1:0]   tgt_idx;
    logic [AGE_W-1:0]   hit_age;
    logic               full;
    logic               touch;
    logic [SIZE-1:0]    age_up;

    // --------------------------------------------------------------------
    // Key match and slot selection
    // --------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            match[i] = valid[i] && (keys[i] == op_key);
        end
    end

    // Downward scan so the lowest index wins
    always_comb begin
        hit_idx    = '0;
        free_idx   = '0;
        victim_idx = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (valid[i] && (ages[i] == OLDEST)) begin
                victim_idx = IDX_W'(i);
            end
        end
    end

    assign full    = &valid;
    assign hit_age = ages[hit_idx];

    assign lookup_hit   = |match;
    assign lookup_value = lookup_hit ? values[hit_idx] : '0;

    // New key goes to a free slot, else replaces the LRU entry
    assign ins_new = (op == OP_WRITE) && !lookup_hit;
    assign evict   = ins_new && full;
    assign tgt_idx = full ? victim_idx : free_idx;

    // Read hit or write hit counts as a use
    assign touch = lookup_hit && ((op == OP_WRITE) || (op == OP_READ));

    // --------------------------------------------------------------------
    // Age update
    // --------------------------------------------------------------------

    // Entries younger than the touched one shift back by one
    // On insert every other valid entry ages
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            if (touch) begin
                age_up[i] = valid[i] && (ages[i] < hit_age);
            end else if (ins_new) begin
                age_up[i] = valid[i] && (IDX_W'(i) != tgt_idx);
            end else begin
                age_up[i] = 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------
    // State update
    // --------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < SIZE; i++) begin
                if ((op == OP_CLEAR) && (clr_idx == IDX_W'(i))) begin
                    valid[i] <= 1'b0;
                end else if (ins_new && (tgt_idx == IDX_W'(i))) begin
                    valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SIZE; i++) begin
            if (ins_new && (tgt_idx == IDX_W'(i))) begin
                // Fresh entry is the most recently used
                keys[i]   <= op_key;
                values[i] <= op_value;
                ages[i]   <= '0;
            end else if (touch && (hit_idx == IDX_W'(i))) begin
                if (op == OP_WRITE) begin
                    values[i] <= op_value;
                end
                ages[i] <= '0;
            end else if (age_up[i]) begin
                ages[i] <= ages[i] + 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------

    // Update in place keeps keys unique across all entries
    a_key_unique: assert property (@(posedge clk) disable iff (rst)
        ((op == OP_WRITE) || (op == OP_READ)) |-> $onehot0(match));

    // Full store holds a strict age order
    for (genvar i = 0; i < SIZE; i++) begin : g_age_chk
        for (genvar j = i + 1; j < SIZE; j++) begin : g_pair
            a_age_distinct: assert property (@(posedge clk) disable iff (rst)
                full |-> (ages[i] != ages[j]));
        end
    end

endmodule

// File: source/stash_lru.sv
`timescale 1ns/1ps

module stash_lru #(
    parameter int KEY_W   = stash_pkg::DEF_KEY_W,
    parameter int VALUE_W = stash_pkg::DEF_VALUE_W,
    parameter int SIZE    = stash_pkg::DEF_SIZE
)(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      init,
    output logic                      init_done,

    input  logic                      wr_req,
    input  logic [KEY_W-1:0]          wr_key,
    input  logic [VALUE_W-1:0]        wr_value,
    output logic                      wr_rdy,

    input  logic                      rd_req,
    input  logic [KEY_W-1:0]          rd_key,
    output logic                      rd_rdy,

    output logic                      rd_ack,
    output logic                      rd_hit,
    output logic [VALUE_W-1:0]        rd_value,

    output logic [$clog2(SIZE+1)-1:0] fill,
    output logic                      evt_activate,
    output logic                      evt_deactivate
);

    import stash_pkg::*;

    localparam int IDX_W  = $clog2(SIZE);
    localparam int FILL_W = $clog2(SIZE + 1);

    // Controller to store
    op_e                op;
    logic [KEY_W-1:0]   op_key;
    logic [VALUE_W-1:0] op_value;
    logic [IDX_W-1:0]   clr_idx;

    // Store to controller and wrapper
    logic               lookup_hit;
    logic [VALUE_W-1:0] lookup_value;
    logic               ins_new;
    logic               evict;

    // --------------------------------------------------------------------
    // Controller and store
    // --------------------------------------------------------------------

    stash_ctrl #(
        .KEY_W   (KEY_W),
        .VALUE_W (VALUE_W),
        .SIZE    (SIZE)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .init         (init),
        .init_done    (init_done),
        .wr_req       (wr_req),
        .wr_key       (wr_key),
        .wr_value     (wr_value),
        .wr_rdy       (wr_rdy),
        .rd_req       (rd_req),
        .rd_key       (rd_key),
        .rd_rdy       (rd_rdy),
        .op           (op),
        .op_key       (op_key),
        .op_value     (op_value),
        .clr_idx      (clr_idx),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .rd_ack       (rd_ack),
        .rd_hit       (rd_hit),
        .rd_value     (rd_value)
    );

    lru_store #(
        .KEY_W   (KEY_W),
        .VALUE_W (VALUE_W),
        .SIZE    (SIZE)
    ) u_store (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .op_key       (op_key),
        .op_value     (op_value),
        .clr_idx      (clr_idx),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .ins_new      (ins_new),
        .evict        (evict)
    );

    // --------------------------------------------------------------------
    // Status
    // --------------------------------------------------------------------

    assign evt_activate   = ins_new;
    assign evt_deactivate = evict;

    // Eviction replaces an entry so the count holds
    always_ff @(posedge clk) begin
        if (rst || (op == OP_CLEAR)) begin
            fill <= '0;
        end else if (ins_new && !evict) begin
            fill <= fill + 1'b1;
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (rst)
        fill <= FILL_W'(SIZE));

    // Store only evicts from a full store to make room for a new key
    a_evict_with_ins: assert property (@(posedge clk) disable iff (rst)
        evict |-> (ins_new && (fill == FILL_W'(SIZE))));

endmodule

// File: source/stash_top.sv
`timescale 1ns/1ps

module stash_top #(
    parameter int KEY_W   = stash_pkg::DEF_KEY_W,
    parameter int VALUE_W = stash_pkg::DEF_VALUE_W,
    parameter int SIZE    = stash_pkg::DEF_SIZE
)(
    input  logic                      clk,
    input  logic                      rst,

    // Init
    input  logic                      init,
    output logic                      init_done,

    // Write side
    input  logic                      wr_req,
    input  logic [KEY_W-1:0]          wr_key,
    input  logic [VALUE_W-1:0]        wr_value,
    output logic                      wr_rdy,

    // Read side
    input  logic                      rd_req,
    input  logic [KEY_W-1:0]          rd_key,
    output logic                      rd_rdy,
    output logic                      rd_ack,
    output logic                      rd_hit,
    output logic [VALUE_W-1:0]        rd_value,

    // Status
    output logic [$clog2(SIZE+1)-1:0] fill,
    output logic                      evt_activate,
    output logic                      evt_deactivate
);

    stash_lru #(
        .KEY_W   (KEY_W),
        .VALUE_W (VALUE_W),
        .SIZE    (SIZE)
    ) u_stash_lru (
        .clk            (clk),
        .rst            (rst),
        .init           (init),
        .init_done      (init_done),
        .wr_req         (wr_req),
        .wr_key         (wr_key),
        .wr_value       (wr_value),
        .wr_rdy         (wr_rdy),
        .rd_req         (rd_req),
        .rd_key         (rd_key),
        .rd_rdy         (rd_rdy),
        .rd_ack         (rd_ack),
        .rd_hit         (rd_hit),
        .rd_value       (rd_value),
        .fill           (fill),
        .evt_activate   (evt_activate),
        .evt_deactivate (evt_deactivate)
    );

endmodule

// File: test/stash_tb.sv
`timescale 1ns/1ps

module stash_tb;

    import stash_pkg::*;

    localparam int KEY_W   = DEF_KEY_W;
    localparam int VALUE_W = DEF_VALUE_W;
    localparam int SIZE    = DEF_SIZE;
    localparam int FILL_W  = $clog2(SIZE + 1);
    localparam int TIMEOUT = 50;

    typedef enum logic [1:0] {T_WRITE, T_READ, T_INIT, T_WRITE_READ} row_op_e;
    typedef enum logic [1:0] {SIG_WR_RDY, SIG_RD_RDY, SIG_RD_ACK, SIG_INIT_DONE} sig_e;

    // One stimulus row and its expected response
    typedef struct packed {
        row_op_e            op;
        logic [KEY_W-1:0]   key;
        logic [VALUE_W-1:0] value;
        logic               exp_hit;
        logic [VALUE_W-1:0] exp_value;
        logic [FILL_W-1:0]  exp_fill;
        logic [1:0]         exp_evt;  // {activate, deactivate}
    } row_t;

    logic               clk;
    logic               rst;
    logic               init;
    logic               init_done;
    logic               wr_req;
    logic [KEY_W-1:0]   wr_key;
    logic [VALUE_W-1:0] wr_value;
    logic               wr_rdy;
    logic               rd_req;
    logic [KEY_W-1:0]   rd_key;
    logic               rd_rdy;
    logic               rd_ack;
    logic               rd_hit;
    logic [VALUE_W-1:0] rd_value;
    logic [FILL_W-1:0]  fill;
    logic               evt_activate;
    logic               evt_deactivate;

    row_t  rows  [$];
    string names [$];

    stash_top #(.KEY_W(KEY_W), .VALUE_W(VALUE_W), .SIZE(SIZE)) u_stash_top (.*);

    // 40 ns period
    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [VALUE_W-1:0] exp,
                               input logic [VALUE_W-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] rd_value expected %h actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] rd_hit expected %b actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_fill(input string name, input logic [FILL_W-1:0] exp,
                              input logic [FILL_W-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] fill expected %0d actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    // Events packed as {evt_activate, evt_deactivate}
    task automatic check_event(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] events expected %b actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    // ------------------------------------------------------------------
    // Waits sampled at the falling edge
    // ------------------------------------------------------------------

    function automatic logic signal_level(input sig_e sel);
        case (sel)
            SIG_WR_RDY: return wr_rdy;
            SIG_RD_RDY: return rd_rdy;
            SIG_RD_ACK: return rd_ack;
            default:    return init_done;
        endcase
    endfunction

    task automatic wait_high(input sig_e sel, input string sig_name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (signal_level(sel) !== 1'b1) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("Timeout: %s never came high within %0d cycles", sig_name, TIMEOUT);
                stop_on_failure();
            end
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------

    task automatic add_row(input string name, input row_op_e op, input int key, input int value,
                           input logic exp_hit, input int exp_value, input int exp_fill,
                           input logic [1:0] exp_evt);
        row_t r;
        r.op        = op;
        r.key       = KEY_W'(key);
        r.value     = VALUE_W'(value);
        r.exp_hit   = exp_hit;
        r.exp_value = VALUE_W'(exp_value);
        r.exp_fill  = FILL_W'(exp_fill);
        r.exp_evt   = exp_evt;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Key k first holds 'hA000 + k
    task automatic build_table();
        add_row("read_empty", T_READ, 5, 0, 1'b0, 0, 0, 2'b00);
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("write_k%0d", k), T_WRITE, k, 'hA000 + k, 1'b0, 0, k + 1, 2'b10);
        end
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("read_k%0d", k), T_READ, k, 0, 1'b1, 'hA000 + k, 4, 2'b00);
        end
        add_row("update_k2", T_WRITE, 2, 'hBEEF, 1'b0, 0, 4, 2'b00);
        add_row("read_update_k2", T_READ, 2, 0, 1'b1, 'hBEEF, 4, 2'b00);
        for (int k = 4; k < 8; k++) begin
            add_row($sformatf("write_k%0d", k), T_WRITE, k, 'hA000 + k, 1'b0, 0, k + 1, 2'b10);
        end
        // Key 0 refreshed, so key 1 is now least recently used
        add_row("refresh_k0", T_READ, 0, 0, 1'b1, 'hA000, 8, 2'b00);
        add_row("evict_k1", T_WRITE, 9, 'h9999, 1'b0, 0, 8, 2'b11);
        add_row("read_evicted_k1", T_READ, 1, 0, 1'b0, 0, 8, 2'b00);
        add_row("read_kept_k0", T_READ, 0, 0, 1'b1, 'hA000, 8, 2'b00);
        add_row("read_new_k9", T_READ, 9, 0, 1'b1, 'h9999, 8, 2'b00);
        add_row("conflict_k3", T_WRITE_READ, 3, 'h3333, 1'b1, 'h3333, 8, 2'b00);
        add_row("init_clear", T_INIT, 0, 0, 1'b0, 0, 0, 2'b00);
        add_row("read_cleared_k0", T_READ, 0, 0, 1'b0, 0, 0, 2'b00);
        add_row("read_cleared_k9", T_READ, 9, 0, 1'b0, 0, 0, 2'b00);
        add_row("write_after_init_k4", T_WRITE, 4, 'h4444, 1'b0, 0, 1, 2'b10);
        add_row("read_after_init_k4", T_READ, 4, 0, 1'b1, 'h4444, 1, 2'b00);
    endtask

    // Row starts and ends just after a rising edge
    task automatic apply_row(input int idx);
        row_t r;
        r = rows[idx];
        if (r.op == T_INIT) begin
            init <= 1'b1;
            @(posedge clk);
            init <= 1'b0;
            @(negedge clk);
            if (init_done !== 1'b0) begin
                $display("init_done did not drop after the init pulse in %s", names[idx]);
                stop_on_failure();
            end
            wait_high(SIG_INIT_DONE, "init_done");
            check_fill(names[idx], r.exp_fill, fill);
        end else begin
            wr_req   <= (r.op != T_READ);
            rd_req   <= (r.op != T_WRITE);
            wr_key   <= r.key;
            wr_value <= r.value;
            rd_key   <= r.key;
            if (r.op == T_READ) begin
                wait_high(SIG_RD_RDY, "rd_rdy");
            end else begin
                wait_high(SIG_WR_RDY, "wr_rdy");
            end
            // Pending write must hold the read back
            if ((r.op == T_WRITE_READ) && (rd_rdy !== 1'b0)) begin
                $display("rd_rdy was high while a write was pending in %s", names[idx]);
                stop_on_failure();
            end
            check_event(names[idx], r.exp_evt, {evt_activate, evt_deactivate});
            @(posedge clk);
            wr_req <= 1'b0;
            if (r.op == T_WRITE_READ) begin
                wait_high(SIG_RD_RDY, "rd_rdy");
                @(posedge clk);
            end
            rd_req <= 1'b0;
            if (r.op == T_WRITE) begin
                @(negedge clk);
            end else begin
                wait_high(SIG_RD_ACK, "rd_ack");
                check_hit(names[idx], r.exp_hit, rd_hit);
                check_value(names[idx], r.exp_value, rd_value);
            end
            check_fill(names[idx], r.exp_fill, fill);
        end
        @(posedge clk);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        init     = 1'b0;
        wr_req   = 1'b0;
        wr_key   = '0;
        wr_value = '0;
        rd_req   = 1'b0;
        rd_key   = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        if ({init_done, wr_rdy, rd_rdy, rd_ack} !== 4'b0000) begin
            $display("Handshake outputs were not low during reset");
            stop_on_failure();
        end
        check_fill("reset", '0, fill);
        check_event("reset", 2'b00, {evt_activate, evt_deactivate});
        // Third reset edge
        @(posedge clk);
        rst <= 1'b0;
        wait_high(SIG_INIT_DONE, "init_done");
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: build.f
source/stash_pkg.sv
source/stash_ctrl.sv
source/lru_store.sv
source/stash_lru.sv
source/stash_top.sv
test/stash_tb.sv
